/* design/dns_rx_config.svh */
`ifndef DNS_RX_CONFIG_SVH
`define DNS_RX_CONFIG_SVH

// header lengths in bytes
`define ETH_HDR_BYTES 14
`define IP_HDR_BYTES 20
`define UDP_HDR_BYTES 8
`define DNS_HDR_BYTES 12

// protocol numbers
`define ETHERTYPE_IPV4 16'h0800
`define IP_PROTO_UDP 8'd17

// reset value of the DNS port register
`define DNS_DEFAULT_PORT 16'd53

// register bus
`define APB_ADDR_W 8
`define APB_DATA_W 32

`endif

/* design/net_pkg.sv */
`default_nettype none

package net_pkg;

    typedef logic [47:0] mac_addr_t;
    typedef logic [31:0] ip_addr_t;

    // one byte of the frame stream
    typedef struct packed {
        logic [7:0] data;
        logic       last;
        logic       user;
    } byte_beat_t;

    typedef struct packed {
        mac_addr_t   dst_mac;
        mac_addr_t   src_mac;
        logic [15:0] ethertype;
    } eth_hdr_t;

    typedef struct packed {
        mac_addr_t   src_mac;
        ip_addr_t    src_ip;
        ip_addr_t    dst_ip;
        logic [15:0] total_len;
    } ip_meta_t;

    typedef struct packed {
        ip_meta_t    ip;
        logic [15:0] src_port;
        logic [15:0] dst_port;
        logic [15:0] udp_len;
    } udp_meta_t;

    // fields kept from a captured query or answer
    typedef struct packed {
        logic [15:0] id;
        logic [15:0] flags;
        logic [15:0] qdcount;
        logic [15:0] ancount;
        ip_addr_t    src_ip;
        mac_addr_t   src_mac;
        logic [15:0] src_port;
    } dns_record_t;

endpackage

`default_nettype wire

/* design/apb_pkg.sv */
`default_nettype none

`include "dns_rx_config.svh"

package apb_pkg;

    typedef struct packed {
        logic [`APB_ADDR_W-1:0] paddr;
        logic                   psel;
        logic                   penable;
        logic                   pwrite;
        logic [`APB_DATA_W-1:0] pwdata;
    } apb_req_t;

    typedef struct packed {
        logic [`APB_DATA_W-1:0] prdata;
        logic                   pready;
        logic                   pslverr;
    } apb_rsp_t;

    // byte offsets of the register map
    typedef enum logic [`APB_ADDR_W-1:0] {
        CTRL_PORT       = 8'h00,
        MATCH_MAC_LO    = 8'h04,
        MATCH_MAC_HI    = 8'h08,
        STATUS          = 8'h0C,
        FRAME_COUNT     = 8'h10,
        DNS_COUNT       = 8'h14,
        REC_ID_FLAGS    = 8'h18,
        REC_COUNTS      = 8'h1C,
        REC_SRC_IP      = 8'h20,
        REC_MAC_LO      = 8'h24,
        REC_MAC_HI_PORT = 8'h28
    } reg_addr_e;

endpackage

`default_nettype wire

/* design/eth_hdr_parser.sv */
`default_nettype none

`include "dns_rx_config.svh"

module eth_hdr_parser (
    input  wire logic                clk,
    input  wire logic                rst,
    input  wire net_pkg::byte_beat_t s_beat,
    input  wire logic                s_valid,
    output net_pkg::byte_beat_t      m_beat,
    output logic                     m_valid,
    output net_pkg::eth_hdr_t        hdr,
    output logic                     hdr_valid,
    output logic                     frame_end
);

    localparam int unsigned HDR_LAST = `ETH_HDR_BYTES - 1;

    logic [3:0]        cnt;
    logic              fwd;
    logic              pend;
    logic [103:0]      sr;
    net_pkg::eth_hdr_t hdr_full;
    logic              accept;

    // last header byte completes the struct
    assign hdr_full = {sr, s_beat.data};
    assign accept   = hdr_full.ethertype == `ETHERTYPE_IPV4;

    always_ff @(posedge clk) begin
        if (rst) begin
            cnt       <= '0;
            fwd       <= 1'b0;
            pend      <= 1'b0;
            m_valid   <= 1'b0;
            hdr_valid <= 1'b0;
            frame_end <= 1'b0;
        end else begin
            m_valid   <= 1'b0;
            hdr_valid <= 1'b0;
            frame_end <= s_valid && s_beat.last;
            if (s_valid) begin
                m_beat <= s_beat;
                if (cnt <= 4'(HDR_LAST)) begin
                    sr  <= {sr[95:0], s_beat.data};
                    cnt <= cnt + 4'd1;
                    if (cnt == 4'(HDR_LAST)) begin
                        hdr       <= hdr_full;
                        fwd       <= accept;
                        pend      <= accept;
                        // empty payload, so the header pulse goes out now
                        hdr_valid <= accept && s_beat.last;
                    end
                end else if (fwd) begin
                    m_valid   <= 1'b1;
                    hdr_valid <= pend;
                    pend      <= 1'b0;
                end
                if (s_beat.last) begin
                    cnt  <= '0;
                    fwd  <= 1'b0;
                    pend <= 1'b0;
                end
            end
        end
    end

endmodule

`default_nettype wire

/* design/ip_hdr_parser.sv */
`default_nettype none

`include "dns_rx_config.svh"

module ip_hdr_parser (
    input  wire logic                clk,
    input  wire logic                rst,
    input  wire net_pkg::byte_beat_t s_beat,
    input  wire logic                s_valid,
    input  wire net_pkg::eth_hdr_t   eth_hdr,
    input  wire logic                eth_hdr_valid,
    output net_pkg::byte_beat_t      m_beat,
    output logic                     m_valid,
    output net_pkg::ip_meta_t        meta,
    output logic                     meta_valid
);

    localparam int unsigned HDR_LAST = `IP_HDR_BYTES - 1;

    logic [4:0]         cnt;
    logic               fwd;
    logic               pend;
    logic [151:0]       sr;
    logic [159:0]       hdr_full;
    net_pkg::mac_addr_t src_mac_q;
    logic               accept;

    assign hdr_full = {sr, s_beat.data};

    // version 4, no options, UDP only
    assign accept = hdr_full[159:156] == 4'd4
                 && hdr_full[155:152] == 4'd5
                 && hdr_full[87:80] == `IP_PROTO_UDP;

    always_ff @(posedge clk) begin
        if (eth_hdr_valid) begin
            src_mac_q <= eth_hdr.src_mac;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            cnt        <= '0;
            fwd        <= 1'b0;
            pend       <= 1'b0;
            m_valid    <= 1'b0;
            meta_valid <= 1'b0;
        end else begin
            m_valid    <= 1'b0;
            meta_valid <= 1'b0;
            if (s_valid) begin
                m_beat <= s_beat;
                if (cnt <= 5'(HDR_LAST)) begin
                    sr  <= {sr[143:0], s_beat.data};
                    cnt <= cnt + 5'd1;
                    if (cnt == 5'(HDR_LAST)) begin
                        fwd        <= accept;
                        pend       <= accept;
                        meta_valid <= accept && s_beat.last;
                        if (accept) begin
                            meta.src_mac   <= src_mac_q;
                            meta.src_ip    <= hdr_full[63:32];
                            meta.dst_ip    <= hdr_full[31:0];
                            meta.total_len <= hdr_full[143:128];
                        end
                    end
                end else if (fwd) begin
                    m_valid    <= 1'b1;
                    meta_valid <= pend;
                    pend       <= 1'b0;
                end
                if (s_beat.last) begin
                    cnt  <= '0;
                    fwd  <= 1'b0;
                    pend <= 1'b0;
                end
            end
        end
    end

endmodule

`default_nettype wire

/* design/udp_hdr_parser.sv */
`default_nettype none

`include "dns_rx_config.svh"

module udp_hdr_parser (
    input  wire logic                clk,
    input  wire logic                rst,
    input  wire net_pkg::byte_beat_t s_beat,
    input  wire logic                s_valid,
    input  wire net_pkg::ip_meta_t   ip_meta,
    input  wire logic                ip_meta_valid,
    output net_pkg::byte_beat_t      m_beat,
    output logic                     m_valid,
    output net_pkg::udp_meta_t       meta,
    output logic                     meta_valid
);

    localparam int unsigned HDR_LAST = `UDP_HDR_BYTES - 1;

    logic [3:0]        cnt;
    logic              pend;
    logic [55:0]       sr;
    logic [63:0]       hdr_full;
    net_pkg::ip_meta_t ip_q;

    assign hdr_full = {sr, s_beat.data};

    always_ff @(posedge clk) begin
        if (ip_meta_valid) begin
            ip_q <= ip_meta;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            cnt        <= '0;
            pend       <= 1'b0;
            m_valid    <= 1'b0;
            meta_valid <= 1'b0;
        end else begin
            m_valid    <= 1'b0;
            meta_valid <= 1'b0;
            if (s_valid) begin
                m_beat <= s_beat;
                if (cnt <= 4'(HDR_LAST)) begin
                    sr  <= {sr[47:0], s_beat.data};
                    cnt <= cnt + 4'd1;
                    if (cnt == 4'(HDR_LAST)) begin
                        // checksum in the low word is not kept
                        meta       <= {ip_q, hdr_full[63:16]};
                        pend       <= 1'b1;
                        meta_valid <= s_beat.last;
                    end
                end else begin
                    m_valid    <= 1'b1;
                    meta_valid <= pend;
                    pend       <= 1'b0;
                end
                if (s_beat.last) begin
                    cnt  <= '0;
                    pend <= 1'b0;
                end
            end
        end
    end

endmodule

`default_nettype wire

/* design/dns_capture.sv */
`default_nettype none

`include "dns_rx_config.svh"

module dns_capture (
    input  wire logic                clk,
    input  wire logic                rst,
    input  wire net_pkg::byte_beat_t s_beat,
    input  wire logic                s_valid,
    input  wire net_pkg::udp_meta_t  udp_meta,
    input  wire logic                udp_meta_valid,
    input  wire logic [15:0]         dns_port,
    output net_pkg::dns_record_t     rec,
    output logic                     rec_valid
);

    localparam int unsigned HDR_BYTES = `DNS_HDR_BYTES;

    logic [3:0]  cnt;
    logic        err;
    logic        port_ok;
    logic [95:0] sr;
    logic [3:0]  cur_cnt;
    logic        cur_err;
    logic        cur_port_ok;
    logic [95:0] dns_hdr;

    // the metadata pulse marks the first payload byte of a datagram
    assign cur_cnt     = udp_meta_valid ? 4'd0 : cnt;
    assign cur_err     = udp_meta_valid ? 1'b0 : err;
    assign cur_port_ok = udp_meta_valid ? (udp_meta.dst_port == dns_port) : port_ok;

    // header as it stands once this byte is in
    assign dns_hdr = (cur_cnt < 4'(HDR_BYTES)) ? {sr[87:0], s_beat.data} : sr;

    always_ff @(posedge clk) begin
        if (rst) begin
            cnt       <= '0;
            err       <= 1'b0;
            port_ok   <= 1'b0;
            rec_valid <= 1'b0;
        end else begin
            rec_valid <= 1'b0;
            if (s_valid) begin
                port_ok <= cur_port_ok;
                err     <= cur_err || s_beat.user;
                cnt     <= cur_cnt;
                if (cur_cnt < 4'(HDR_BYTES)) begin
                    sr  <= {sr[87:0], s_beat.data};
                    cnt <= cur_cnt + 4'd1;
                end
                if (s_beat.last) begin
                    rec_valid <= cur_port_ok && !cur_err && !s_beat.user
                              && cur_cnt >= 4'(HDR_BYTES - 1);
                    rec.id       <= dns_hdr[95:80];
                    rec.flags    <= dns_hdr[79:64];
                    rec.qdcount  <= dns_hdr[63:48];
                    rec.ancount  <= dns_hdr[47:32];
                    rec.src_ip   <= udp_meta.ip.src_ip;
                    rec.src_mac  <= udp_meta.ip.src_mac;
                    rec.src_port <= udp_meta.src_port;
                end
            end
        end
    end

endmodule

`default_nettype wire

/* design/dns_regs.sv */
`default_nettype none

`include "dns_rx_config.svh"

module dns_regs (
    input  wire logic                 clk,
    input  wire logic                 rst,
    input  wire apb_pkg::apb_req_t    apb_req,
    output apb_pkg::apb_rsp_t         apb_rsp,
    input  wire logic                 frame_end,
    input  wire net_pkg::dns_record_t rec,
    input  wire logic                 rec_valid,
    output logic [15:0]               dns_port
);

    logic                       access;
    logic                       wr;
    apb_pkg::reg_addr_e         addr;
    logic [`APB_DATA_W-1:0]     rdata;
    logic                       mapped;
    logic                       read_only;
    net_pkg::mac_addr_t         match_mac;
    logic [`APB_DATA_W-1:0]     frame_cnt;
    logic [`APB_DATA_W-1:0]     dns_cnt;
    net_pkg::dns_record_t       rec_q;
    logic                       seen;
    logic                       mac_match;

    assign access = apb_req.psel && apb_req.penable;
    assign wr     = access && apb_req.pwrite;
    assign addr   = apb_pkg::reg_addr_e'(apb_req.paddr);

    // read mux and decode
    always_comb begin
        rdata     = '0;
        mapped    = 1'b1;
        read_only = 1'b1;
        case (addr)
            apb_pkg::CTRL_PORT: begin
                rdata     = {16'd0, dns_port};
                read_only = 1'b0;
            end
            apb_pkg::MATCH_MAC_LO: begin
                rdata     = match_mac[31:0];
                read_only = 1'b0;
            end
            apb_pkg::MATCH_MAC_HI: begin
                rdata     = {16'd0, match_mac[47:32]};
                read_only = 1'b0;
            end
            apb_pkg::STATUS:          rdata = {30'd0, mac_match, seen};
            apb_pkg::FRAME_COUNT:     rdata = frame_cnt;
            apb_pkg::DNS_COUNT:       rdata = dns_cnt;
            apb_pkg::REC_ID_FLAGS:    rdata = {rec_q.id, rec_q.flags};
            apb_pkg::REC_COUNTS:      rdata = {rec_q.qdcount, rec_q.ancount};
            apb_pkg::REC_SRC_IP:      rdata = rec_q.src_ip;
            apb_pkg::REC_MAC_LO:      rdata = rec_q.src_mac[31:0];
            apb_pkg::REC_MAC_HI_PORT: rdata = {rec_q.src_mac[47:32], rec_q.src_port};
            default:                  mapped = 1'b0;
        endcase
    end

    assign apb_rsp.prdata  = rdata;
    assign apb_rsp.pready  = 1'b1;
    assign apb_rsp.pslverr = access && (!mapped || (apb_req.pwrite && read_only));

    always_ff @(posedge clk) begin
        if (rst) begin
            dns_port  <= `DNS_DEFAULT_PORT;
            match_mac <= '0;
            frame_cnt <= '0;
            dns_cnt   <= '0;
            rec_q     <= '0;
            seen      <= 1'b0;
            mac_match <= 1'b0;
        end else begin
            if (wr) begin
                case (addr)
                    apb_pkg::CTRL_PORT:    dns_port <= apb_req.pwdata[15:0];
                    apb_pkg::MATCH_MAC_LO: match_mac[31:0] <= apb_req.pwdata;
                    apb_pkg::MATCH_MAC_HI: match_mac[47:32] <= apb_req.pwdata[15:0];
                    default: ;
                endcase
            end
            if (frame_end) begin
                frame_cnt <= frame_cnt + 1'b1;
            end
            if (rec_valid) begin
                rec_q     <= rec;
                dns_cnt   <= dns_cnt + 1'b1;
                seen      <= 1'b1;
                // compared once per record against the programmed MAC
                mac_match <= rec.src_mac == match_mac;
            end
        end
    end

endmodule

`default_nettype wire

/* design/dns_rx_top.sv */
`default_nettype none

module dns_rx_top (
    input  wire logic                clk,
    input  wire logic                rst,
    input  wire net_pkg::byte_beat_t s_beat,
    input  wire logic                s_valid,
    output logic                     s_ready,
    input  wire apb_pkg::apb_req_t   apb_req,
    output apb_pkg::apb_rsp_t        apb_rsp
);

    net_pkg::byte_beat_t  eth_beat;
    logic                 eth_valid;
    net_pkg::eth_hdr_t    eth_hdr;
    logic                 eth_hdr_valid;
    logic                 frame_end;
    net_pkg::byte_beat_t  ip_beat;
    logic                 ip_valid;
    net_pkg::ip_meta_t    ip_meta;
    logic                 ip_meta_valid;
    net_pkg::byte_beat_t  udp_beat;
    logic                 udp_valid;
    net_pkg::udp_meta_t   udp_meta;
    logic                 udp_meta_valid;
    net_pkg::dns_record_t rec;
    logic                 rec_valid;
    logic [15:0]          dns_port;

    // every stage takes a byte per cycle
    assign s_ready = 1'b1;

    eth_hdr_parser u_eth (
        .clk       (clk),
        .rst       (rst),
        .s_beat    (s_beat),
        .s_valid   (s_valid),
        .m_beat    (eth_beat),
        .m_valid   (eth_valid),
        .hdr       (eth_hdr),
        .hdr_valid (eth_hdr_valid),
        .frame_end (frame_end)
    );

    ip_hdr_parser u_ip (
        .clk           (clk),
        .rst           (rst),
        .s_beat        (eth_beat),
        .s_valid       (eth_valid),
        .eth_hdr       (eth_hdr),
        .eth_hdr_valid (eth_hdr_valid),
        .m_beat        (ip_beat),
        .m_valid       (ip_valid),
        .meta          (ip_meta),
        .meta_valid    (ip_meta_valid)
    );

    udp_hdr_parser u_udp (
        .clk           (clk),
        .rst           (rst),
        .s_beat        (ip_beat),
        .s_valid       (ip_valid),
        .ip_meta       (ip_meta),
        .ip_meta_valid (ip_meta_valid),
        .m_beat        (udp_beat),
        .m_valid       (udp_valid),
        .meta          (udp_meta),
        .meta_valid    (udp_meta_valid)
    );

    dns_capture u_dns (
        .clk            (clk),
        .rst            (rst),
        .s_beat         (udp_beat),
        .s_valid        (udp_valid),
        .udp_meta       (udp_meta),
        .udp_meta_valid (udp_meta_valid),
        .dns_port       (dns_port),
        .rec            (rec),
        .rec_valid      (rec_valid)
    );

    dns_regs u_regs (
        .clk       (clk),
        .rst       (rst),
        .apb_req   (apb_req),
        .apb_rsp   (apb_rsp),
        .frame_end (frame_end),
        .rec       (rec),
        .rec_valid (rec_valid),
        .dns_port  (dns_port)
    );

endmodule

`default_nettype wire

/* verif/tb_dns_rx_top.sv */
`default_nettype none

`include "dns_rx_config.svh"

module tb_dns_rx_top;

    timeunit 1ns;
    timeprecision 1ps;

    localparam string INPUT_FILE = "verif/dns_rx_input.txt";

    logic                clk = 1'b0;
    logic                rst;
    net_pkg::byte_beat_t s_beat;
    logic                s_valid;
    logic                s_ready;
    apb_pkg::apb_req_t   apb_req;
    apb_pkg::apb_rsp_t   apb_rsp;

    // operations and frame bytes read from the input file
    logic [7:0]          op_kind[$];
    logic [31:0]         op_a[$];
    logic [31:0]         op_b[$];
    logic [7:0]          frame_bytes[$];

    int unsigned         watchdog_cycles = 0;
    logic [31:0]         rng_state;

    dns_rx_top DUT (
        .clk     (clk),
        .rst     (rst),
        .s_beat  (s_beat),
        .s_valid (s_valid),
        .s_ready (s_ready),
        .apb_req (apb_req),
        .apb_rsp (apb_rsp)
    );

    always #50 clk = ~clk;

    task automatic fail_run();
        $display("Errors found");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_value(input string name, input logic [`APB_DATA_W-1:0] actual,
                               input logic [`APB_DATA_W-1:0] expected);
        if (actual !== expected) begin
            $display("Mismatch %s: got 0x%08h, expected 0x%08h", name, actual, expected);
            fail_run();
        end
    endtask

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic string reg_name(input logic [`APB_ADDR_W-1:0] offset);
        case (offset)
            apb_pkg::CTRL_PORT:       return "CTRL_PORT";
            apb_pkg::MATCH_MAC_LO:    return "MATCH_MAC_LO";
            apb_pkg::MATCH_MAC_HI:    return "MATCH_MAC_HI";
            apb_pkg::STATUS:          return "STATUS";
            apb_pkg::FRAME_COUNT:     return "FRAME_COUNT";
            apb_pkg::DNS_COUNT:       return "DNS_COUNT";
            apb_pkg::REC_ID_FLAGS:    return "REC_ID_FLAGS";
            apb_pkg::REC_COUNTS:      return "REC_COUNTS";
            apb_pkg::REC_SRC_IP:      return "REC_SRC_IP";
            apb_pkg::REC_MAC_LO:      return "REC_MAC_LO";
            apb_pkg::REC_MAC_HI_PORT: return "REC_MAC_HI_PORT";
            default:                  return $sformatf("offset 0x%02h", offset);
        endcase
    endfunction

    // whole file is parsed up front so the watchdog limit is known
    task automatic load_input();
        int           fd;
        int           code;
        logic [63:0]  token;
        logic [1279:0] line;
        logic [31:0]  a;
        logic [31:0]  b;
        logic [7:0]   data;
        int unsigned  n_bytes;
        int unsigned  n_frames;
        int unsigned  n_apb;
        n_bytes  = 0;
        n_frames = 0;
        n_apb    = 0;
        fd = $fopen(INPUT_FILE, "r");
        if (fd == 0) begin
            $display("Cannot open the input file %s", INPUT_FILE);
            fail_run();
        end
        while (!$feof(fd)) begin
            code = $fscanf(fd, "%s", token);
            if (code != 1) begin
                break;
            end
            if (token == "#") begin
                code = $fgets(line, fd);
            end else if (token == "F") begin
                code = $fscanf(fd, "%d", a);
                for (int unsigned i = 0; i < a; i++) begin
                    code = $fscanf(fd, "%h", data);
                    frame_bytes.push_back(data);
                end
                code = $fscanf(fd, "%h", b);
                op_kind.push_back(token[7:0]);
                op_a.push_back(a);
                op_b.push_back(b);
                n_bytes  += a;
                n_frames += 1;
            end else if (token == "W" || token == "E" || token == "X") begin
                code = $fscanf(fd, "%h %h", a, b);
                op_kind.push_back(token[7:0]);
                op_a.push_back(a);
                op_b.push_back(b);
                n_apb += 1;
            end else begin
                $display("Unknown line kind %s in the input file", token);
                fail_run();
            end
        end
        $fclose(fd);
        // reset cycles on top of the per-operation budget
        watchdog_cycles = n_bytes * 4 + n_frames * 200 + n_apb * 20 + 20;
    endtask

    task automatic send_frame(input int unsigned count, input logic last_user);
        logic [7:0]  data;
        int unsigned gap;
        // the stream input never pushes back
        check_value("S_READY", s_ready, 1);
        for (int unsigned i = 0; i < count; i++) begin
            rng_state = xorshift32(rng_state);
            gap = rng_state[1:0];
            repeat (gap) begin
                @(posedge clk);
                s_valid <= 1'b0;
            end
            data = frame_bytes.pop_front();
            @(posedge clk);
            s_valid     <= 1'b1;
            s_beat.data <= data;
            s_beat.last <= (i == count - 1);
            s_beat.user <= (i == count - 1) && last_user;
        end
        @(posedge clk);
        s_valid <= 1'b0;
        s_beat  <= '0;
        // let the parser chain drain
        repeat (10) @(posedge clk);
    endtask

    task automatic apb_access(input logic [`APB_ADDR_W-1:0] addr, input logic write,
                              input logic [`APB_DATA_W-1:0] wdata,
                              output logic [`APB_DATA_W-1:0] rdata, output logic slverr);
        @(posedge clk);
        apb_req.paddr   <= addr;
        apb_req.psel    <= 1'b1;
        apb_req.penable <= 1'b0;
        apb_req.pwrite  <= write;
        apb_req.pwdata  <= wdata;
        @(posedge clk);
        apb_req.penable <= 1'b1;
        // pready is always high, so the access cycle ends at the next edge
        @(negedge clk);
        rdata  = apb_rsp.prdata;
        slverr = apb_rsp.pslverr;
        check_value("PREADY", apb_rsp.pready, 1);
        @(posedge clk);
        apb_req <= '0;
    endtask

    initial begin
        logic [`APB_DATA_W-1:0] rdata;
        logic                   slverr;
        logic [7:0]             kind;
        logic [31:0]            a;
        logic [31:0]            b;
        rst       = 1'b1;
        s_valid   = 1'b0;
        s_beat    = '0;
        apb_req   = '0;
        rng_state = 32'd4486;
        load_input();
        repeat (3) @(posedge clk);
        rst <= 1'b0;
        while (op_kind.size() > 0) begin
            kind = op_kind.pop_front();
            a    = op_a.pop_front();
            b    = op_b.pop_front();
            case (kind)
                "W": begin
                    apb_access(a[7:0], 1'b1, b, rdata, slverr);
                    check_value($sformatf("%s PSLVERR", reg_name(a[7:0])), slverr, 0);
                end
                "E": begin
                    apb_access(a[7:0], 1'b0, '0, rdata, slverr);
                    check_value(reg_name(a[7:0]), rdata, b);
                    check_value($sformatf("%s PSLVERR", reg_name(a[7:0])), slverr, 0);
                end
                "X": begin
                    // all ones so a write that slips through shows up
                    apb_access(a[7:0], b[0], '1, rdata, slverr);
                    check_value($sformatf("%s PSLVERR", reg_name(a[7:0])), slverr, 1);
                end
                default: send_frame(a, b[0]);
            endcase
        end
        $display("No errors");
        $finish;
    end

    // watchdog
    initial begin
        wait (watchdog_cycles != 0);
        repeat (watchdog_cycles) @(posedge clk);
        $display("Timeout: the tests did not complete within %0d clock cycles",
                 watchdog_cycles);
        fail_run();
    end

endmodule

`default_nettype wire

/* dns_rx.f */
+incdir+design
design/net_pkg.sv
design/apb_pkg.sv
design/eth_hdr_parser.sv
design/ip_hdr_parser.sv
design/udp_hdr_parser.sv
design/dns_capture.sv
design/dns_regs.sv
design/dns_rx_top.sv
verif/tb_dns_rx_top.sv

/* Bender.yml */
package:
  name: dns_rx

sources:
  - include_dirs:
      - design
    files:
      - design/net_pkg.sv
      - design/apb_pkg.sv
      - design/eth_hdr_parser.sv
      - design/ip_hdr_parser.sv
      - design/udp_hdr_parser.sv
      - design/dns_capture.sv
      - design/dns_regs.sv
      - design/dns_rx_top.sv
  - target: simulation
    include_dirs:
      - design
    files:
      - verif/tb_dns_rx_top.sv

/* verif/dns_rx_input.txt */
# W off val: APB write | E off val: read and compare | X off wr: expect PSLVERR, wr 1 = write
# F count (decimal), then count bytes in hex, then the user flag of the last byte
# registers after reset
E 00 00000035
E 04 00000000
E 08 00000000
E 0c 00000000
E 10 00000000
E 14 00000000
E 18 00000000
E 1c 00000000
E 20 00000000
E 24 00000000
E 28 00000000
# DNS query to port 53 from 02:11:22:33:44:55, 192.168.1.10:50000
F 54
02 00 00 00 00 01 02 11 22 33 44 55 08 00 45 00 00 28 00 01 00 00 40 11 00 00 c0
a8 01 0a c0 a8 01 01 c3 50 00 35 00 14 00 00 12 34 01 00 00 01 00 00 00 00 00 00  0
E 10 00000001
E 14 00000001
E 0c 00000001
E 18 12340100
E 1c 00010000
E 20 c0a8010a
E 24 22334455
E 28 0211c350
# ethertype 86dd
F 54
02 00 00 00 00 01 02 11 22 33 44 55 86 dd 45 00 00 28 00 01 00 00 40 11 00 00 c0
a8 01 0a c0 a8 01 01 c3 50 00 35 00 14 00 00 bb bb 01 00 00 01 00 00 00 00 00 00  0
# TCP protocol
F 54
02 00 00 00 00 01 02 11 22 33 44 55 08 00 45 00 00 28 00 01 00 00 40 06 00 00 c0
a8 01 0a c0 a8 01 01 c3 50 00 35 00 14 00 00 cc cc 01 00 00 01 00 00 00 00 00 00  0
# IHL 6
F 54
02 00 00 00 00 01 02 11 22 33 44 55 08 00 46 00 00 28 00 01 00 00 40 11 00 00 c0
a8 01 0a c0 a8 01 01 c3 50 00 35 00 14 00 00 dd dd 01 00 00 01 00 00 00 00 00 00  0
# only 11 DNS bytes
F 53
02 00 00 00 00 01 02 11 22 33 44 55 08 00 45 00 00 27 00 01 00 00 40 11 00 00 c0
a8 01 0a c0 a8 01 01 c3 50 00 35 00 13 00 00 ee ee 01 00 00 01 00 00 00 00 00  0
# user set on the last byte
F 54
02 00 00 00 00 01 02 11 22 33 44 55 08 00 45 00 00 28 00 01 00 00 40 11 00 00 c0
a8 01 0a c0 a8 01 01 c3 50 00 35 00 14 00 00 ff ff 01 00 00 01 00 00 00 00 00 00  1
E 10 00000006
E 14 00000001
E 18 12340100
E 20 c0a8010a
E 28 0211c350
# move the DNS port to 5353
W 00 000014e9
E 00 000014e9
F 54
02 00 00 00 00 01 02 11 22 33 44 55 08 00 45 00 00 28 00 01 00 00 40 11 00 00 c0
a8 01 0a c0 a8 01 01 c3 50 00 35 00 14 00 00 77 77 01 00 00 01 00 00 00 00 00 00  0
E 14 00000001
# response to port 5353 from 02:aa:bb:cc:dd:ee, 192.168.1.20:8080
F 54
02 00 00 00 00 01 02 aa bb cc dd ee 08 00 45 00 00 28 00 02 00 00 40 11 00 00 c0
a8 01 14 c0 a8 01 01 1f 90 14 e9 00 14 00 00 53 53 81 80 00 01 00 02 00 00 00 00  0
E 10 00000008
E 14 00000002
E 0c 00000001
E 18 53538180
E 1c 00010002
E 20 c0a80114
E 24 bbccddee
E 28 02aa1f90
# match MAC 02:aa:bb:cc:dd:ee
W 04 bbccddee
W 08 000002aa
E 04 bbccddee
E 08 000002aa
F 54
02 00 00 00 00 01 02 aa bb cc dd ee 08 00 45 00 00 28 00 02 00 00 40 11 00 00 c0
a8 01 14 c0 a8 01 01 1f 90 14 e9 00 14 00 00 44 44 81 80 00 01 00 02 00 00 00 00  0
E 0c 00000003
E 14 00000003
E 18 44448180
# another source MAC clears mac_match
F 54
02 00 00 00 00 01 02 11 22 33 44 55 08 00 45 00 00 28 00 01 00 00 40 11 00 00 c0
a8 01 0a c0 a8 01 01 c3 50 14 e9 00 14 00 00 55 55 01 00 00 01 00 00 00 00 00 00  0
E 0c 00000001
E 14 00000004
E 18 55550100
E 24 22334455
E 28 0211c350
E 10 0000000a
# unmapped read, write to a read-only counter
X 40 0
X 14 1
E 14 00000004
